//--- build.f
hdl/flash_pkg.sv
hdl/host_pkg.sv
hdl/prog_regs.sv
hdl/prog_sequencer.sv
hdl/spi_shifter.sv
hdl/flash_prog_top.sv
verification/spi_flash_monitor.sv
verification/tb_flash_prog.sv

//--- hdl/flash_pkg.sv
// SPI NOR flash side definitions

package flash_pkg;

   localparam int addr_width = 24; // three address bytes
   localparam int word_width = 16; // data words are sent MSB first

   // one-byte opcodes used by the programming sequence
   typedef enum logic [7:0] {
      op_wake         = 8'hAB, // release from deep power-down
      op_write_enable = 8'h06,
      op_page_program = 8'h02
   } flash_op_e;

endpackage

//--- hdl/flash_prog_top.sv
`timescale 1ns/1ns

// SPI flash programming controller top level

module flash_prog_top #(
   parameter int sck_div    = 8,  // clocks per SPI bit, even and >= 4
   parameter int gap_cycles = 16  // CS high time after AB and 06
) (
   input  logic                             clk,
   input  logic                             reset,
   input  host_pkg::prog_job_t              cmd,
   input  logic                             cmd_req,
   output logic                             cmd_ack,
   output logic                             busy,
   output logic                             word_req,
   input  logic                             word_ack,
   input  logic [flash_pkg::word_width-1:0] word_data,
   output logic                             spi_sck,
   output logic                             spi_ss_n,
   output logic                             spi_mosi
);

   host_pkg::prog_job_t              job;
   logic                             start;
   logic                             done;
   logic                             shift_load;
   logic [flash_pkg::word_width-1:0] shift_data;
   logic [4:0]                       shift_bits;
   logic                             shift_done;

   prog_regs u_regs (
      .clk     (clk),
      .reset   (reset),
      .cmd     (cmd),
      .cmd_req (cmd_req),
      .cmd_ack (cmd_ack),
      .busy    (busy),
      .job     (job),
      .start   (start),
      .done    (done)
   );

   prog_sequencer #(
      .gap_cycles (gap_cycles)
   ) u_seq (
      .clk        (clk),
      .reset      (reset),
      .job        (job),
      .start      (start),
      .done       (done),
      .word_req   (word_req),
      .word_ack   (word_ack),
      .word_data  (word_data),
      .shift_load (shift_load),
      .shift_data (shift_data),
      .shift_bits (shift_bits),
      .shift_done (shift_done),
      .spi_ss_n   (spi_ss_n)
   );

   spi_shifter #(
      .sck_div (sck_div)
   ) u_shift (
      .clk        (clk),
      .reset      (reset),
      .shift_load (shift_load),
      .shift_data (shift_data),
      .shift_bits (shift_bits),
      .shift_done (shift_done),
      .spi_sck    (spi_sck),
      .spi_mosi   (spi_mosi)
   );

endmodule

//--- hdl/host_pkg.sv
// host side job description and sequencer states

package host_pkg;

   // one programming job as handed over by the host
   typedef struct packed {
      logic [flash_pkg::addr_width-1:0] addr;       // start address
      logic [7:0]                       word_count; // 0 sends opcode and address only
      logic                             do_wake;    // send AB frame first
   } prog_job_t;

   typedef enum logic [3:0] {
      st_idle,
      st_wake,
      st_wake_gap,
      st_we,
      st_we_gap,
      st_cmd,
      st_addr,
      st_word_fetch,
      st_word_send,
      st_end_gap
   } seq_state_e;

endpackage

//--- hdl/prog_regs.sv
`timescale 1ns/1ns

// job register block
// accepts one job at a time over a four-phase req/ack channel and
// holds it stable for the sequencer until the job is done

module prog_regs (
   input  logic                clk,
   input  logic                reset,
   input  host_pkg::prog_job_t cmd,
   input  logic                cmd_req,
   output logic                cmd_ack,
   output logic                busy,
   output host_pkg::prog_job_t job,
   output logic                start,
   input  logic                done
);

   logic accept;

   // a new job is only taken once the previous handshake has closed
   assign accept = cmd_req && !cmd_ack && !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_ack <= 1'b0;
         busy    <= 1'b0;
         start   <= 1'b0;
      end else begin
         start <= 1'b0; // single cycle pulse

         if (accept) begin
            cmd_ack <= 1'b1;
            busy    <= 1'b1;
            start   <= 1'b1;
         end else if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0; // host released req, close the handshake
         end

         // done only arrives while busy, never in the accept cycle
         if (done) begin
            busy <= 1'b0;
         end
      end
   end

   // job payload, stable for as long as busy is high
   always_ff @(posedge clk) begin
      if (accept) begin
         job <= cmd;
      end
   end

endmodule

//--- hdl/prog_sequencer.sv
`timescale 1ns/1ns

// frame sequencing for one programming job
// optional AB frame, 06 frame, then one 02 frame with address and data words

module prog_sequencer #(
   parameter int gap_cycles = 16
) (
   input  logic                             clk,
   input  logic                             reset,
   input  host_pkg::prog_job_t              job,
   input  logic                             start,
   output logic                             done,
   output logic                             word_req,
   input  logic                             word_ack,
   input  logic [flash_pkg::word_width-1:0] word_data,
   output logic                             shift_load,
   output logic [flash_pkg::word_width-1:0] shift_data,
   output logic [4:0]                       shift_bits,
   input  logic                             shift_done,
   output logic                             spi_ss_n
);

   localparam int gap_w = $clog2(gap_cycles + 1);
   localparam logic [gap_w-1:0] gap_last = gap_w'(gap_cycles - 1);

   host_pkg::seq_state_e             state;
   logic [gap_w-1:0]                 gap_cnt;
   logic [1:0]                       byte_cnt;   // address bytes left after the current one
   logic [7:0]                       words_left;
   logic [flash_pkg::addr_width-1:0] addr_sr;
   logic                             word_held;  // word latched while ack is still high

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= host_pkg::st_idle;
         gap_cnt    <= '0;
         byte_cnt   <= '0;
         words_left <= '0;
         word_held  <= 1'b0;
         word_req   <= 1'b0;
         shift_load <= 1'b0;
         done       <= 1'b0;
         spi_ss_n   <= 1'b1;
      end else begin
         shift_load <= 1'b0;
         done       <= 1'b0;

         case (state)
            host_pkg::st_idle: begin
               if (start) begin
                  spi_ss_n   <= 1'b0;
                  shift_load <= 1'b1;
                  shift_bits <= 5'd8;
                  addr_sr    <= job.addr;
                  words_left <= job.word_count;
                  if (job.do_wake) begin
                     shift_data <= {flash_pkg::op_wake, 8'h00};
                     state      <= host_pkg::st_wake;
                  end else begin
                     shift_data <= {flash_pkg::op_write_enable, 8'h00};
                     state      <= host_pkg::st_we;
                  end
               end
            end

            host_pkg::st_wake: begin
               if (shift_done) begin
                  spi_ss_n <= 1'b1;
                  gap_cnt  <= '0;
                  state    <= host_pkg::st_wake_gap;
               end
            end

            host_pkg::st_wake_gap: begin
               gap_cnt <= gap_cnt + 1'b1;
               if (gap_cnt == gap_last) begin // flash needs time to wake up
                  spi_ss_n   <= 1'b0;
                  shift_load <= 1'b1;
                  shift_bits <= 5'd8;
                  shift_data <= {flash_pkg::op_write_enable, 8'h00};
                  state      <= host_pkg::st_we;
               end
            end

            host_pkg::st_we: begin
               if (shift_done) begin
                  spi_ss_n <= 1'b1; // rising CS latches write enable
                  gap_cnt  <= '0;
                  state    <= host_pkg::st_we_gap;
               end
            end

            host_pkg::st_we_gap: begin
               gap_cnt <= gap_cnt + 1'b1;
               if (gap_cnt == gap_last) begin
                  spi_ss_n   <= 1'b0;
                  shift_load <= 1'b1;
                  shift_bits <= 5'd8;
                  shift_data <= {flash_pkg::op_page_program, 8'h00};
                  state      <= host_pkg::st_cmd;
               end
            end

            host_pkg::st_cmd: begin
               if (shift_done) begin
                  shift_load <= 1'b1;
                  shift_data <= {addr_sr[flash_pkg::addr_width-1 -: 8], 8'h00};
                  addr_sr    <= addr_sr << 8;
                  byte_cnt   <= 2'd2;
                  state      <= host_pkg::st_addr;
               end
            end

            host_pkg::st_addr: begin
               if (shift_done) begin
                  if (byte_cnt != 2'd0) begin
                     shift_load <= 1'b1;
                     shift_data <= {addr_sr[flash_pkg::addr_width-1 -: 8], 8'h00};
                     addr_sr    <= addr_sr << 8;
                     byte_cnt   <= byte_cnt - 2'd1;
                  end else if (words_left == 8'd0) begin
                     spi_ss_n <= 1'b1; // address only without data
                     gap_cnt  <= '0;
                     state    <= host_pkg::st_end_gap;
                  end else begin
                     state <= host_pkg::st_word_fetch;
                  end
               end
            end

            // CS stays low here for as long as the host takes
            host_pkg::st_word_fetch: begin
               if (!word_req && !word_held) begin
                  word_req <= 1'b1;
               end
               if (word_req && word_ack) begin
                  word_req   <= 1'b0;
                  shift_data <= word_data;
                  word_held  <= 1'b1;
               end
               if (word_held && !word_ack) begin
                  word_held  <= 1'b0;
                  shift_load <= 1'b1;
                  shift_bits <= 5'd16;
                  state      <= host_pkg::st_word_send;
               end
            end

            host_pkg::st_word_send: begin
               if (shift_done) begin
                  words_left <= words_left - 8'd1;
                  if (words_left == 8'd1) begin
                     spi_ss_n <= 1'b1; // last word starts the program cycle
                     gap_cnt  <= '0;
                     state    <= host_pkg::st_end_gap;
                  end else begin
                     state <= host_pkg::st_word_fetch;
                  end
               end
            end

            host_pkg::st_end_gap: begin
               gap_cnt <= gap_cnt + 1'b1;
               if (gap_cnt == gap_w'(1)) begin
                  done  <= 1'b1;
                  state <= host_pkg::st_idle;
               end
            end

            default: state <= host_pkg::st_idle;
         endcase
      end
   end

   // ack of the previous word must be gone before the next request
   a_word_req_after_ack : assert property (@(posedge clk) disable iff (reset)
      $rose(word_req) |-> !$past(word_ack))
      else $error("word_req raised while word_ack still high");

   a_cs_high_in_gap : assert property (@(posedge clk) disable iff (reset)
      state inside {host_pkg::st_wake_gap, host_pkg::st_we_gap, host_pkg::st_end_gap}
      |-> spi_ss_n)
      else $error("chip select low during a gap");

endmodule

//--- hdl/spi_shifter.sv
`timescale 1ns/1ns

// SPI mode 0 serializer
// each bit lasts sck_div clocks, MOSI changes at the start of the bit
// and SCK is high during the second half

module spi_shifter #(
   parameter int sck_div = 8
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            shift_load,
   input  logic [flash_pkg::word_width-1:0] shift_data,
   input  logic [4:0]                      shift_bits,
   output logic                            shift_done,
   output logic                            spi_sck,
   output logic                            spi_mosi
);

   localparam int phase_w = $clog2(sck_div);
   localparam logic [phase_w-1:0] half_phase = phase_w'(sck_div / 2 - 1);
   localparam logic [phase_w-1:0] last_phase = phase_w'(sck_div - 1);

   logic                             active;
   logic [phase_w-1:0]               phase_cnt;
   logic [4:0]                       bit_cnt;   // bits still to send after this one
   logic [flash_pkg::word_width-1:0] shreg;

   always_ff @(posedge clk) begin
      if (reset) begin
         active     <= 1'b0;
         phase_cnt  <= '0;
         bit_cnt    <= '0;
         shift_done <= 1'b0;
         spi_sck    <= 1'b0;
         spi_mosi   <= 1'b0;
      end else begin
         shift_done <= 1'b0;

         if (shift_load) begin
            active    <= 1'b1;
            phase_cnt <= '0;
            bit_cnt   <= shift_bits - 5'd1;
            spi_mosi  <= shift_data[flash_pkg::word_width-1]; // MSB goes first
            shreg     <= shift_data << 1;
         end else if (active) begin
            phase_cnt <= phase_cnt + 1'b1;
            if (phase_cnt == half_phase) begin
               spi_sck <= 1'b1; // flash samples on this edge
            end
            if (phase_cnt == last_phase) begin
               spi_sck   <= 1'b0;
               phase_cnt <= '0;
               if (bit_cnt == 5'd0) begin
                  active     <= 1'b0;
                  shift_done <= 1'b1;
                  spi_mosi   <= 1'b0;
               end else begin
                  bit_cnt  <= bit_cnt - 5'd1;
                  spi_mosi <= shreg[flash_pkg::word_width-1];
                  shreg    <= shreg << 1;
               end
            end
         end
      end
   end

   // the sequencer must wait for shift_done before loading again
   a_no_load_while_busy : assert property (@(posedge clk) disable iff (reset)
      shift_load |-> !active)
      else $error("shift_load while a shift is in progress");

endmodule

//--- run.sh
#!/bin/sh
# compile and run the flash programming testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
   --top-module tb_flash_prog -f build.f -o sim_flash_prog

# a $fatal in the testbench makes this return a failing status
./obj_dir/sim_flash_prog

//--- verification/spi_flash_monitor.sv
`timescale 1ns/1ns

// SPI mode 0 bus monitor
// assembles MOSI bits into bytes for every low chip select frame
// and records how long chip select was high before each frame

module spi_flash_monitor (
   input logic clk,
   input logic reset,
   input logic spi_sck,
   input logic spi_ss_n,
   input logic spi_mosi
);

   logic [7:0] byte_q[$];       // bytes of all frames, in bus order
   int         len_q[$];        // byte count of each closed frame
   int         gap_q[$];        // CS high clocks before each frame
   int         stray_bits = 0;  // SCK edges seen with CS high
   int         partial_frames = 0;

   int         frame_id = 0;
   int         open_bytes = 0;
   int         hi_cnt = 0;
   logic       ss_q = 1'b1;
   int         bit_frame = 0;   // frame that the bit counter belongs to
   int         nbits = 0;
   logic [7:0] shreg = 8'h00;

   // frame boundaries and CS high time, on the system clock
   always @(posedge clk) begin
      if (reset) begin
         ss_q   = 1'b1;
         hi_cnt = 0;
      end else begin
         if (!spi_ss_n && ss_q) begin
            gap_q.push_back(hi_cnt); // frame opens
            open_bytes = byte_q.size();
            frame_id++;
         end else if (spi_ss_n && !ss_q) begin
            len_q.push_back(byte_q.size() - open_bytes);
            if (bit_frame == frame_id && nbits != 0) begin
               partial_frames++;
            end
            hi_cnt = 1;
         end else if (spi_ss_n) begin
            hi_cnt++;
         end
         ss_q = spi_ss_n;
      end
   end

   // flash side sampling, MSB first
   always @(posedge spi_sck) begin
      if (!reset) begin
         if (spi_ss_n) begin
            stray_bits++;
         end else begin
            if (bit_frame != frame_id) begin
               nbits     = 0; // first bit of a new frame
               bit_frame = frame_id;
            end
            shreg = {shreg[6:0], spi_mosi};
            nbits++;
            if (nbits == 8) begin
               byte_q.push_back(shreg);
               nbits = 0;
            end
         end
      end
   end

endmodule

//--- verification/tb_flash_prog.sv
`timescale 1ns/1ns

// testbench for the SPI flash programming controller
// jobs come from a table, data words from a seeded random source

module tb_flash_prog;

   localparam int sck_div    = 8;
   localparam int gap_cycles = 16;
   localparam int num_rows   = 6;

   typedef struct packed {
      host_pkg::prog_job_t job;
      logic                overlap;   // request raised while the previous job runs
      logic [7:0]          ack_delay; // clocks before each word acknowledge
   } row_t;

   logic                clk = 1'b0;
   logic                reset;
   host_pkg::prog_job_t cmd;
   logic                cmd_req;
   logic                cmd_ack;
   logic                busy;
   logic                word_req;
   logic                word_ack;
   logic [15:0]         word_data;
   logic                spi_sck;
   logic                spi_ss_n;
   logic                spi_mosi;

   logic [15:0] sent_words[$]; // every word handed to the DUT
   logic [7:0]  exp_frame[$];
   int          frame_rd = 0;
   int          byte_rd = 0;
   int          word_rd = 0;

   always #10 clk = ~clk;

   flash_prog_top #(
      .sck_div    (sck_div),
      .gap_cycles (gap_cycles)
   ) dut_i (
      .clk       (clk),
      .reset     (reset),
      .cmd       (cmd),
      .cmd_req   (cmd_req),
      .cmd_ack   (cmd_ack),
      .busy      (busy),
      .word_req  (word_req),
      .word_ack  (word_ack),
      .word_data (word_data),
      .spi_sck   (spi_sck),
      .spi_ss_n  (spi_ss_n),
      .spi_mosi  (spi_mosi)
   );

   spi_flash_monitor mon_i (
      .clk      (clk),
      .reset    (reset),
      .spi_sck  (spi_sck),
      .spi_ss_n (spi_ss_n),
      .spi_mosi (spi_mosi)
   );

   // columns: address, word count, wake, overlap, ack delay
   function automatic row_t job_row(input int idx);
      row_t r;
      case (idx)
         0: r = {24'h123456, 8'd3, 1'b1, 1'b0, 8'd0};
         1: r = {24'hABCDEF, 8'd2, 1'b0, 1'b0, 8'd0};
         2: r = {24'h00FF01, 8'd4, 1'b0, 1'b0, 8'd25}; // slow host
         3: r = {24'h7E8001, 8'd0, 1'b1, 1'b0, 8'd0};  // address only
         4: r = {24'h010203, 8'd2, 1'b1, 1'b1, 8'd3};
         5: r = {24'hFEDCBA, 8'd1, 1'b0, 1'b1, 8'd12};
         default: r = '0;
      endcase
      return r;
   endfunction

   // bits times sck_div, gaps and word delays per job, doubled
   function automatic int budget_cycles();
      row_t r;
      int   i;
      int   words;
      int   total;
      total = 20;
      for (i = 0; i < num_rows; i++) begin
         r     = job_row(i);
         words = 32'(r.job.word_count);
         total += (40 + 16 * words) * sck_div + gap_cycles + 40;
         total += words * (32'(r.ack_delay) + 8);
         if (r.job.do_wake) begin
            total += 8 * sck_div + gap_cycles;
         end
      end
      return 2 * total;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s expected %0h actual %0h", name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "run stopped at the first error");
      end
   endtask

   // four-phase command handshake, optionally started while busy
   task automatic issue_job(input int idx, input host_pkg::prog_job_t job,
                            input logic hold_off);
      @(negedge clk);
      cmd     = job;
      cmd_req = 1'b1;
      if (hold_off) begin
         check($sformatf("job %0d busy at request", idx), 1, 32'(busy));
         while (busy) begin
            check($sformatf("job %0d ack while busy", idx), 0, 32'(cmd_ack));
            @(negedge clk);
         end
      end
      while (!cmd_ack) @(negedge clk);
      cmd_req = 1'b0;
      while (cmd_ack) @(negedge clk);
   endtask

   task automatic serve_word(input int idx, input int delay);
      logic [31:0] rnd;
      int          d;
      while (!word_req) @(negedge clk);
      for (d = 0; d < delay; d++) begin
         // frame must stay open and SCK quiet while the host is slow
         check($sformatf("job %0d cs in stall", idx), 0, 32'(spi_ss_n));
         check($sformatf("job %0d sck in stall", idx), 0, 32'(spi_sck));
         @(negedge clk);
      end
      rnd       = $urandom();
      word_data = rnd[15:0];
      word_ack  = 1'b1;
      sent_words.push_back(rnd[15:0]);
      while (word_req) @(negedge clk);
      word_ack = 1'b0;
   endtask

   task automatic compare_frame(input int idx, input string tag, input logic gap_after);
      int len;
      int b;
      check($sformatf("job %0d %s frame present", idx, tag), 1,
            32'(mon_i.len_q.size() > frame_rd));
      len = mon_i.len_q[frame_rd];
      check($sformatf("job %0d %s frame length", idx, tag), exp_frame.size(), len);
      for (b = 0; b < len; b++) begin
         check($sformatf("job %0d %s byte %0d", idx, tag, b), 32'(exp_frame[b]),
               32'(mon_i.byte_q[byte_rd + b]));
      end
      if (gap_after) begin
         check($sformatf("job %0d gap after %s", idx, tag), gap_cycles,
               mon_i.gap_q[frame_rd + 1]);
      end
      frame_rd++;
      byte_rd += len;
      exp_frame = {};
   endtask

   task automatic verify_job(input int idx);
      row_t        r;
      int          w;
      logic [15:0] wv;
      r = job_row(idx);
      if (r.job.do_wake) begin
         exp_frame.push_back(flash_pkg::op_wake);
         compare_frame(idx, "wake", 1'b1);
      end
      exp_frame.push_back(flash_pkg::op_write_enable);
      compare_frame(idx, "write enable", 1'b1);
      exp_frame.push_back(flash_pkg::op_page_program);
      exp_frame.push_back(r.job.addr[23:16]);
      exp_frame.push_back(r.job.addr[15:8]);
      exp_frame.push_back(r.job.addr[7:0]);
      for (w = 0; w < 32'(r.job.word_count); w++) begin
         wv = sent_words[word_rd];
         word_rd++;
         exp_frame.push_back(wv[15:8]); // high byte first
         exp_frame.push_back(wv[7:0]);
      end
      compare_frame(idx, "program", 1'b0);
   endtask

   initial begin : word_host
      row_t r;
      int   j;
      int   w;
      word_ack  = 1'b0;
      word_data = 16'h0000;
      void'($urandom(34));
      @(negedge reset);
      for (j = 0; j < num_rows; j++) begin
         r = job_row(j);
         for (w = 0; w < 32'(r.job.word_count); w++) begin
            serve_word(j, 32'(r.ack_delay));
         end
      end
   end

   initial begin : host_main
      row_t r;
      row_t next_r;
      int   i;
      int   verified;
      reset    = 1'b1;
      cmd      = '0;
      cmd_req  = 1'b0;
      verified = 0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check("idle cmd_ack", 0, 32'(cmd_ack));
      check("idle busy", 0, 32'(busy));
      check("idle word_req", 0, 32'(word_req));
      check("idle spi_ss_n", 1, 32'(spi_ss_n));
      check("idle spi_sck", 0, 32'(spi_sck));
      check("idle spi_mosi", 0, 32'(spi_mosi));
      check("idle frames", 0, mon_i.gap_q.size());
      for (i = 0; i < num_rows; i++) begin
         r = job_row(i);
         issue_job(i, r.job, r.overlap);
         next_r = job_row(i + 1);
         if (!next_r.overlap) begin
            while (busy) @(negedge clk);
            while (verified <= i) begin // overlapped jobs are checked together
               verify_job(verified);
               verified++;
            end
         end
      end
      check("frames opened", frame_rd, mon_i.gap_q.size());
      check("frames closed", frame_rd, mon_i.len_q.size());
      check("frames ending mid byte", 0, mon_i.partial_frames);
      check("sck outside a frame", 0, mon_i.stray_bits);
      $display("*** PASSED ***");
      $finish;
   end

   initial begin : watchdog
      int limit;
      limit = budget_cycles();
      repeat (limit) @(posedge clk);
      $display("timeout after %0d clocks, the DUT did not finish the jobs", limit);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

endmodule
